// File: filelist.f
+incdir+include
logic/alu_pkg.sv
logic/alu_sequencer.sv
logic/alu_operand_fetch.sv
logic/alu_nibble_calc.sv
logic/alu_reg_file.sv
logic/saturn_alu.sv
verif/tb_saturn_alu.sv

// File: logic/alu_nibble_calc.sv
`timescale 1ns/10ps

module alu_nibble_calc
  import alu_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_reset,
  input  phase_t  i_phase,
  input  alu_op_t i_op,
  input  logic    i_is_first,
  input  nibble_t i_p_src1,
  input  nibble_t i_p_src2,
  input  logic    i_p_carry,
  output nibble_t o_c_res1,
  output nibble_t o_c_res2,
  output logic    o_c_carry,
  output logic    o_nz_seen
);

  nibble_t res1;
  nibble_t res2;
  logic    carry_out;
  logic    nz_next;

  always_comb begin
    // pass-through for copy and the bit ops
    res1      = i_p_src1;
    res2      = i_p_src2;
    carry_out = o_c_carry;
    nz_next   = o_nz_seen;
    case (i_op)
      ALU_OP_ZERO: begin
        res1 = '0;
      end
      ALU_OP_EXCH: begin
        // swap, second result goes back to src2
        res1 = i_p_src2;
        res2 = i_p_src1;
      end
      ALU_OP_CMPL2: begin
        // invert plus carry, carry ripples over zero nibbles
        {carry_out, res1} = {1'b0, ~i_p_src1} + {{NIBBLE_W{1'b0}}, i_p_carry};
        // any non-zero source nibble so far
        nz_next = (i_is_first ? 1'b0 : o_nz_seen) | (i_p_src1 != '0);
      end
      ALU_OP_ADD: begin
        {carry_out, res1} = {1'b0, i_p_src1} + {1'b0, i_p_src2}
                            + {{NIBBLE_W{1'b0}}, i_p_carry};
      end
      ALU_OP_CLR_MASK: begin
        res1 = i_p_src1 & ~i_p_src2;
      end
      ALU_OP_TEST_EQ,
      ALU_OP_TEST_NEQ: begin
        // sticky mismatch flag carried in the carry
        carry_out = i_p_carry | (i_p_src1 != i_p_src2);
      end
      default: begin
        res1 = i_p_src1;
      end
    endcase
  end

  // result nibbles
  always_ff @(posedge i_clk) begin
    if (i_phase == CALC_PH) begin
      o_c_res1 <= res1;
      o_c_res2 <= res2;
    end
  end

  // running flags
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_c_carry <= 1'b0;
      o_nz_seen <= 1'b0;
    end else if (i_phase == CALC_PH) begin
      o_c_carry <= carry_out;
      o_nz_seen <= nz_next;
    end
  end

endmodule

// File: logic/alu_operand_fetch.sv
`timescale 1ns/10ps

module alu_operand_fetch
  import alu_pkg::*;
(
  input  logic      i_clk,
  input  phase_t    i_phase,
  input  alu_cmd_t  i_cmd,
  input  nib_idx_t  i_f_cur,
  input  logic      i_is_first,
  input  cpu_regs_t i_regs,
  input  logic      i_c_carry,
  output nibble_t   o_p_src1,
  output nibble_t   o_p_src2,
  output logic      o_p_carry
);

  nibble_t src1_nib;
  nibble_t src2_nib;
  logic    carry_in;

  // one nibble of a selected source
  function automatic nibble_t pick_nibble(input cpu_regs_t regs,
                                          input reg_sel_t  sel,
                                          input nib_idx_t  idx,
                                          input nibble_t   imm);
    nibble_t nib;
    case (sel)
      ALU_REG_A:   nib = regs.a[idx*NIBBLE_W +: NIBBLE_W];
      ALU_REG_B:   nib = regs.b[idx*NIBBLE_W +: NIBBLE_W];
      ALU_REG_C:   nib = regs.c[idx*NIBBLE_W +: NIBBLE_W];
      ALU_REG_D:   nib = regs.d[idx*NIBBLE_W +: NIBBLE_W];
      // ST only has four nibbles
      ALU_REG_ST:  nib = regs.st[idx[1:0]*NIBBLE_W +: NIBBLE_W];
      ALU_REG_P:   nib = regs.p;
      ALU_REG_IMM: nib = imm;
      default:     nib = '0;
    endcase
    return nib;
  endfunction

  // source selection by opcode
  always_comb begin
    // zero needs no source at all
    if (i_cmd.op == ALU_OP_ZERO) begin
      src1_nib = '0;
    end else begin
      src1_nib = pick_nibble(i_regs, i_cmd.src1, i_f_cur, i_cmd.imm);
    end
    // second operand for two-input ops only
    case (i_cmd.op)
      ALU_OP_EXCH,
      ALU_OP_ADD,
      ALU_OP_CLR_MASK,
      ALU_OP_TEST_EQ,
      ALU_OP_TEST_NEQ: src2_nib = pick_nibble(i_regs, i_cmd.src2, i_f_cur, i_cmd.imm);
      default:         src2_nib = '0;
    endcase
  end

  // incoming carry, seeded on the first nibble
  always_comb begin
    case (i_cmd.op)
      // +1 of the two's complement
      ALU_OP_CMPL2:    carry_in = i_is_first ? 1'b1 : i_c_carry;
      ALU_OP_ADD,
      ALU_OP_TEST_EQ,
      ALU_OP_TEST_NEQ: carry_in = i_is_first ? 1'b0 : i_c_carry;
      default:         carry_in = i_c_carry;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_phase == PREP_PH) begin
      o_p_src1  <= src1_nib;
      o_p_src2  <= src2_nib;
      o_p_carry <= carry_in;
    end
  end

endmodule

// File: logic/alu_pkg.sv
package alu_pkg;

  // nibble geometry of the working registers
  localparam int NIBBLE_W    = 4;
  localparam int REG_NIBBLES = 16;
  localparam int WORD_W      = NIBBLE_W * REG_NIBBLES;
  // status word, four nibbles
  localparam int ST_W        = 16;

  typedef logic [NIBBLE_W-1:0] nibble_t;
  // field cursor, rolls over from 15 to 0
  typedef logic [$clog2(REG_NIBBLES)-1:0] nib_idx_t;
  typedef logic [WORD_W-1:0] word_t;

  // nibble-serial operations
  typedef enum logic [3:0] {
    ALU_OP_ZERO,
    ALU_OP_COPY,
    ALU_OP_EXCH,
    ALU_OP_CMPL2,
    ALU_OP_ADD,
    ALU_OP_CLR_MASK,
    ALU_OP_SET_BIT,
    ALU_OP_RST_BIT,
    ALU_OP_TEST_EQ,
    ALU_OP_TEST_NEQ
  } alu_op_t;

  // operand and destination selectors
  typedef enum logic [2:0] {
    ALU_REG_A,
    ALU_REG_B,
    ALU_REG_C,
    ALU_REG_D,
    ALU_REG_ST,
    ALU_REG_P,
    ALU_REG_IMM,
    ALU_REG_ZERO
  } reg_sel_t;

  // one nibble per full turn of the phases
  typedef enum logic [1:0] {
    IDLE_PH,
    PREP_PH,
    CALC_PH,
    SAVE_PH
  } phase_t;

  typedef struct packed {
    alu_op_t  op;
    reg_sel_t dest;
    reg_sel_t src1;
    reg_sel_t src2;
    nib_idx_t field_first;
    nib_idx_t field_last;
    nibble_t  imm;
  } alu_cmd_t;

  // visible register state
  typedef struct packed {
    word_t           a;
    word_t           b;
    word_t           c;
    word_t           d;
    logic [ST_W-1:0] st;
    nibble_t         p;
    logic            carry;
  } cpu_regs_t;

endpackage

// File: logic/alu_reg_file.sv
`timescale 1ns/10ps

module alu_reg_file
  import alu_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset,
  input  phase_t    i_phase,
  input  alu_cmd_t  i_cmd,
  input  nib_idx_t  i_f_cur,
  input  logic      i_is_last,
  input  nibble_t   i_c_res1,
  input  nibble_t   i_c_res2,
  input  logic      i_c_carry,
  input  logic      i_nz_seen,
  input  logic      i_run,
  output cpu_regs_t o_regs
);

  cpu_regs_t regs;
  cpu_regs_t regs_next;
  logic      save_en;

  // writes only on the save phase of a running command
  assign save_en = (i_phase == SAVE_PH) && i_run;

  // one nibble written into a selected register
  function automatic cpu_regs_t put_nibble(input cpu_regs_t r,
                                           input reg_sel_t  sel,
                                           input nib_idx_t  idx,
                                           input nibble_t   val);
    cpu_regs_t w;
    w = r;
    case (sel)
      ALU_REG_A:  w.a[idx*NIBBLE_W +: NIBBLE_W] = val;
      ALU_REG_B:  w.b[idx*NIBBLE_W +: NIBBLE_W] = val;
      ALU_REG_C:  w.c[idx*NIBBLE_W +: NIBBLE_W] = val;
      ALU_REG_D:  w.d[idx*NIBBLE_W +: NIBBLE_W] = val;
      // ST nibbles wrap every four
      ALU_REG_ST: w.st[idx[1:0]*NIBBLE_W +: NIBBLE_W] = val;
      ALU_REG_P:  w.p = val;
      // imm and zero are not writable
      default:    w = r;
    endcase
    return w;
  endfunction

  always_comb begin
    regs_next = regs;
    if (save_en) begin
      case (i_cmd.op)
        ALU_OP_ZERO,
        ALU_OP_COPY,
        ALU_OP_CMPL2,
        ALU_OP_ADD,
        ALU_OP_CLR_MASK: begin
          regs_next = put_nibble(regs, i_cmd.dest, i_f_cur, i_c_res1);
        end
        ALU_OP_EXCH: begin
          // both halves of the exchange in one save
          regs_next = put_nibble(regs, i_cmd.dest, i_f_cur, i_c_res1);
          regs_next = put_nibble(regs_next, i_cmd.src2, i_f_cur, i_c_res2);
        end
        ALU_OP_SET_BIT,
        ALU_OP_RST_BIT: begin
          // result nibble is the bit index
          if (i_cmd.dest == ALU_REG_ST) begin
            regs_next.st[i_c_res1] = (i_cmd.op == ALU_OP_SET_BIT);
          end
        end
        default: begin
          // tests write nothing but CARRY
          regs_next = regs;
        end
      endcase

      // CARRY settles on the last nibble
      if (i_is_last) begin
        case (i_cmd.op)
          ALU_OP_ADD:      regs_next.carry = i_c_carry;
          ALU_OP_CMPL2:    regs_next.carry = i_nz_seen;
          ALU_OP_TEST_NEQ: regs_next.carry = i_c_carry;
          ALU_OP_TEST_EQ:  regs_next.carry = !i_c_carry;
          default:         regs_next.carry = regs.carry;
        endcase
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      regs <= '0;
    end else begin
      regs <= regs_next;
    end
  end

  assign o_regs = regs;

endmodule

// File: logic/alu_sequencer.sv
`timescale 1ns/10ps

module alu_sequencer
  import alu_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_reset,
  input  logic     i_start,
  input  alu_cmd_t i_cmd,
  output phase_t   o_phase,
  output alu_cmd_t o_cmd,
  output nib_idx_t o_f_cur,
  output logic     o_is_first,
  output logic     o_is_last,
  output logic     o_busy
);

  phase_t   phase;
  alu_cmd_t cmd;
  nib_idx_t f_cur;
  logic     run;
  logic     done;
  logic     accept;

  // commands only taken on the save edge, and only while idle
  assign accept = (phase == SAVE_PH) && !run && i_start;

  // free-running phase counter
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      phase <= IDLE_PH;
    end else begin
      // wraps save back to idle
      phase <= phase_t'(phase + 2'd1);
    end
  end

  // command latch
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      cmd <= '0;
    end else if (accept) begin
      cmd <= i_cmd;
    end
  end

  // field cursor
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      f_cur <= '0;
    end else if (accept) begin
      f_cur <= i_cmd.field_first;
    end else if (run && (phase == SAVE_PH)) begin
      // next nibble, modulo 16
      f_cur <= f_cur + 1'b1;
    end
  end

  // run and done control
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      run  <= 1'b0;
      done <= 1'b0;
    end else if (accept) begin
      run  <= 1'b1;
      done <= 1'b0;
    end else if (run) begin
      // last nibble known by the calc phase
      if (phase == CALC_PH) begin
        done <= o_is_last;
      end
      // finish on the save of the last nibble
      if ((phase == SAVE_PH) && done) begin
        run  <= 1'b0;
        done <= 1'b0;
      end
    end
  end

  assign o_phase    = phase;
  assign o_cmd      = cmd;
  assign o_f_cur    = f_cur;
  assign o_is_first = (f_cur == cmd.field_first);
  assign o_is_last  = (f_cur == cmd.field_last);
  assign o_busy     = run;

endmodule

// File: logic/saturn_alu.sv
`timescale 1ns/10ps

module saturn_alu
  import alu_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset,
  input  logic      i_start,
  input  alu_cmd_t  i_cmd,
  output logic      o_busy,
  output cpu_regs_t o_regs
);

  // sequencer outputs
  phase_t   phase;
  alu_cmd_t cmd;
  nib_idx_t f_cur;
  logic     is_first;
  logic     is_last;

  // prepare stage
  nibble_t  p_src1;
  nibble_t  p_src2;
  logic     p_carry;

  // calc stage
  nibble_t  c_res1;
  nibble_t  c_res2;
  logic     c_carry;
  logic     nz_seen;

  alu_sequencer u_sequencer (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_start    (i_start),
    .i_cmd      (i_cmd),
    .o_phase    (phase),
    .o_cmd      (cmd),
    .o_f_cur    (f_cur),
    .o_is_first (is_first),
    .o_is_last  (is_last),
    .o_busy     (o_busy)
  );

  // reads the live register state
  alu_operand_fetch u_operand_fetch (
    .i_clk      (i_clk),
    .i_phase    (phase),
    .i_cmd      (cmd),
    .i_f_cur    (f_cur),
    .i_is_first (is_first),
    .i_regs     (o_regs),
    .i_c_carry  (c_carry),
    .o_p_src1   (p_src1),
    .o_p_src2   (p_src2),
    .o_p_carry  (p_carry)
  );

  alu_nibble_calc u_nibble_calc (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_phase    (phase),
    .i_op       (cmd.op),
    .i_is_first (is_first),
    .i_p_src1   (p_src1),
    .i_p_src2   (p_src2),
    .i_p_carry  (p_carry),
    .o_c_res1   (c_res1),
    .o_c_res2   (c_res2),
    .o_c_carry  (c_carry),
    .o_nz_seen  (nz_seen)
  );

  // busy doubles as the write enable
  alu_reg_file u_reg_file (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_phase    (phase),
    .i_cmd      (cmd),
    .i_f_cur    (f_cur),
    .i_is_last  (is_last),
    .i_c_res1   (c_res1),
    .i_c_res2   (c_res2),
    .i_c_carry  (c_carry),
    .i_nz_seen  (nz_seen),
    .i_run      (o_busy),
    .o_regs     (o_regs)
  );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# compile the testbench and the core with Verilator, then run it
# the run counts as passed only if the log holds the pass line

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f --top-module tb_saturn_alu \
  -Mdir obj_dir -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  && grep -q "^STATUS: PASS$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// File: include/alu_ref_model.svh
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// nibbles in a field wrapping past 15
function automatic int field_length(input alu_cmd_t cmd);
  nib_idx_t span;
  span = cmd.field_last - cmd.field_first;
  return int'(span) + 1;
endfunction

function automatic nibble_t read_nibble(input cpu_regs_t r, input reg_sel_t sel,
                                        input nib_idx_t idx, input nibble_t imm);
  case (sel)
    ALU_REG_A:   return r.a[idx*NIBBLE_W +: NIBBLE_W];
    ALU_REG_B:   return r.b[idx*NIBBLE_W +: NIBBLE_W];
    ALU_REG_C:   return r.c[idx*NIBBLE_W +: NIBBLE_W];
    ALU_REG_D:   return r.d[idx*NIBBLE_W +: NIBBLE_W];
    ALU_REG_ST:  return r.st[idx[1:0]*NIBBLE_W +: NIBBLE_W];
    ALU_REG_P:   return r.p;
    ALU_REG_IMM: return imm;
    default:     return '0;
  endcase
endfunction

function automatic cpu_regs_t write_nibble(input cpu_regs_t r, input reg_sel_t sel,
                                           input nib_idx_t idx, input nibble_t val);
  case (sel)
    ALU_REG_A:  r.a[idx*NIBBLE_W +: NIBBLE_W] = val;
    ALU_REG_B:  r.b[idx*NIBBLE_W +: NIBBLE_W] = val;
    ALU_REG_C:  r.c[idx*NIBBLE_W +: NIBBLE_W] = val;
    ALU_REG_D:  r.d[idx*NIBBLE_W +: NIBBLE_W] = val;
    ALU_REG_ST: r.st[idx[1:0]*NIBBLE_W +: NIBBLE_W] = val;
    ALU_REG_P:  r.p = val;
    // imm and zero take no writes
    default:    ;
  endcase
  return r;
endfunction

// runs the whole command one nibble after another
function automatic cpu_regs_t predict_regs(input cpu_regs_t regs, input alu_cmd_t cmd);
  cpu_regs_t r;
  nib_idx_t  idx;
  nibble_t   s1;
  nibble_t   s2;
  nibble_t   res;
  logic      carry;
  logic      nz;
  r     = regs;
  idx   = cmd.field_first;
  // two's complement starts with +1
  carry = (cmd.op == ALU_OP_CMPL2);
  nz    = 1'b0;
  for (int n = 0; n < field_length(cmd); n++) begin
    s1 = read_nibble(r, cmd.src1, idx, cmd.imm);
    s2 = read_nibble(r, cmd.src2, idx, cmd.imm);
    case (cmd.op)
      ALU_OP_ZERO:     r = write_nibble(r, cmd.dest, idx, '0);
      ALU_OP_COPY:     r = write_nibble(r, cmd.dest, idx, s1);
      ALU_OP_EXCH: begin
        r = write_nibble(r, cmd.dest, idx, s2);
        r = write_nibble(r, cmd.src2, idx, s1);
      end
      ALU_OP_CMPL2: begin
        nz = nz | (s1 != '0);
        {carry, res} = {1'b0, ~s1} + 5'(carry);
        r = write_nibble(r, cmd.dest, idx, res);
      end
      ALU_OP_ADD: begin
        {carry, res} = 5'(s1) + 5'(s2) + 5'(carry);
        r = write_nibble(r, cmd.dest, idx, res);
      end
      ALU_OP_CLR_MASK: r = write_nibble(r, cmd.dest, idx, s1 & ~s2);
      ALU_OP_SET_BIT: begin
        if (cmd.dest == ALU_REG_ST) begin
          r.st[s1] = 1'b1;
        end
      end
      ALU_OP_RST_BIT: begin
        if (cmd.dest == ALU_REG_ST) begin
          r.st[s1] = 1'b0;
        end
      end
      // tests keep a sticky mismatch
      default:         carry = carry | (s1 != s2);
    endcase
    idx = idx + 1'b1;
  end
  if (cmd.op == ALU_OP_ADD || cmd.op == ALU_OP_TEST_NEQ) begin
    r.carry = carry;
  end else if (cmd.op == ALU_OP_TEST_EQ) begin
    r.carry = !carry;
  end else if (cmd.op == ALU_OP_CMPL2) begin
    r.carry = nz;
  end
  return r;
endfunction

`endif

// File: verif/tb_saturn_alu.sv
`timescale 1ns/10ps

module tb_saturn_alu
  import alu_pkg::*;
();

  `include "alu_ref_model.svh"

  localparam int CLK_PERIOD = 100;
  localparam int RESET_CYCLES = 10;
  localparam logic [15:0] LFSR_SEED = 16'd4114;
  // preload writes one nibble per command over A to D, ST and P
  localparam int PRELOAD_CMDS = 4 * REG_NIBBLES + 5;
  localparam int RANDOM_CMDS = 300;
  localparam int TOTAL_CMDS = PRELOAD_CMDS + RANDOM_CMDS;
  // worst case 16 nibbles of 4 cycles plus the wait for the save edge
  localparam int WATCHDOG_CYCLES = TOTAL_CMDS * (REG_NIBBLES * 4 + 8) + RESET_CYCLES + 20;

  logic      i_clk;
  logic      i_reset;
  logic      i_start;
  alu_cmd_t  i_cmd;
  logic      o_busy;
  cpu_regs_t o_regs;

  // expected register state
  cpu_regs_t   model_regs;
  logic [15:0] lfsr;

  saturn_alu dut (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_start (i_start),
    .i_cmd   (i_cmd),
    .o_busy  (o_busy),
    .o_regs  (o_regs)
  );

  initial i_clk = 1'b0;
  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("[ERROR] %s expected %h actual %h", name, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // every visible field against the model
  task automatic check_regs(input string name, input cpu_regs_t exp);
    check_value({name, " A"}, exp.a, o_regs.a);
    check_value({name, " B"}, exp.b, o_regs.b);
    check_value({name, " C"}, exp.c, o_regs.c);
    check_value({name, " D"}, exp.d, o_regs.d);
    check_value({name, " ST"}, 64'(exp.st), 64'(o_regs.st));
    check_value({name, " P"}, 64'(exp.p), 64'(o_regs.p));
    check_value({name, " CARRY"}, 64'(exp.carry), 64'(o_regs.carry));
  endtask

  // issue one command, time the busy window, compare the result
  task automatic run_cmd(input string name, input alu_cmd_t cmd);
    cpu_regs_t exp;
    int        cycles;
    int        nibbles;
    exp     = predict_regs(model_regs, cmd);
    nibbles = field_length(cmd);
    i_cmd   = cmd;
    i_start = 1'b1;
    @(negedge i_clk);
    // accepted on the next save edge
    while (!o_busy) begin
      @(negedge i_clk);
    end
    i_start = 1'b0;
    cycles = 0;
    while (o_busy) begin
      cycles++;
      @(negedge i_clk);
    end
    check_value({name, " busy cycles"}, 64'(4 * nibbles), 64'(cycles));
    check_regs(name, exp);
    model_regs = exp;
  endtask

  // single nibble copy of an immediate
  function automatic alu_cmd_t imm_write(input reg_sel_t dest, input nib_idx_t idx);
    alu_cmd_t c;
    c             = '0;
    c.op          = ALU_OP_COPY;
    c.dest        = dest;
    c.src1        = ALU_REG_IMM;
    c.src2        = ALU_REG_ZERO;
    c.field_first = idx;
    c.field_last  = idx;
    c.imm         = nibble_t'(rand_bits(4));
    return c;
  endfunction

  function automatic alu_cmd_t random_cmd();
    alu_cmd_t   c;
    logic [1:0] d;
    logic [1:0] s1;
    logic [1:0] s2;
    logic [3:0] kind;
    c             = '0;
    c.field_first = nib_idx_t'(rand_bits(4));
    c.field_last  = nib_idx_t'(rand_bits(4));
    c.imm         = nibble_t'(rand_bits(4));
    d             = 2'(rand_bits(2));
    s1            = 2'(rand_bits(2));
    s2            = 2'(rand_bits(2));
    kind          = 4'(rand_bits(4));
    // working registers A to D by default
    c.dest = reg_sel_t'({1'b0, d});
    c.src1 = reg_sel_t'({1'b0, s1});
    c.src2 = reg_sel_t'({1'b0, s2});
    case (kind)
      4'd0: c.op = ALU_OP_ZERO;
      4'd1, 4'd2: c.op = ALU_OP_COPY;
      4'd3: begin
        // exchange dest with a different register
        c.op = ALU_OP_EXCH;
        if (s2 == d) begin
          s2 = d ^ 2'b01;
        end
        c.src1 = c.dest;
        c.src2 = reg_sel_t'({1'b0, s2});
      end
      4'd4: begin
        c.op = ALU_OP_CMPL2;
        // a zero source field leaves CARRY clear
        if (s2 == 2'd0) begin
          c.src1 = ALU_REG_ZERO;
        end
      end
      4'd5, 4'd6: c.op = ALU_OP_ADD;
      4'd7: c.op = ALU_OP_CLR_MASK;
      4'd8, 4'd9: begin
        // bit index from the immediate
        c.op   = (kind == 4'd8) ? ALU_OP_SET_BIT : ALU_OP_RST_BIT;
        c.dest = ALU_REG_ST;
        c.src1 = ALU_REG_IMM;
      end
      4'd10: c.op = ALU_OP_TEST_EQ;
      4'd11: c.op = ALU_OP_TEST_NEQ;
      4'd12: begin
        // equal operands give a known verdict
        c.op   = s1[0] ? ALU_OP_TEST_EQ : ALU_OP_TEST_NEQ;
        c.src2 = c.src1;
      end
      4'd13: begin
        c.op   = ALU_OP_COPY;
        c.dest = ALU_REG_ST;
        c.src1 = s2[0] ? ALU_REG_IMM : reg_sel_t'({1'b0, s1});
      end
      4'd14: begin
        c.op   = ALU_OP_COPY;
        c.dest = ALU_REG_P;
        c.src1 = ALU_REG_IMM;
      end
      default: begin
        // immediate as the second operand
        c.op   = s1[1] ? ALU_OP_ADD : ALU_OP_CLR_MASK;
        c.src2 = ALU_REG_IMM;
      end
    endcase
    return c;
  endfunction

  // limit on the whole run
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: the DUT did not finish its commands in time");
    $display("STATUS: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    alu_cmd_t c;
    alu_op_t  op;
    i_reset    = 1'b1;
    i_start    = 1'b0;
    i_cmd      = '0;
    lfsr       = LFSR_SEED;
    model_regs = '0;
    repeat (RESET_CYCLES) @(negedge i_clk);
    i_reset = 1'b0;

    // state right after reset
    check_value("reset busy", 64'd0, 64'(o_busy));
    check_regs("reset", model_regs);

    // random contents for A to D, then ST and P
    for (int r = 0; r < 4; r++) begin
      for (int n = 0; n < REG_NIBBLES; n++) begin
        run_cmd($sformatf("preload r%0d n%0d", r, n),
                imm_write(reg_sel_t'(3'(r)), nib_idx_t'(n)));
      end
    end
    for (int n = 0; n < 4; n++) begin
      run_cmd($sformatf("preload ST n%0d", n), imm_write(ALU_REG_ST, nib_idx_t'(n)));
    end
    run_cmd("preload P", imm_write(ALU_REG_P, '0));

    for (int i = 0; i < RANDOM_CMDS; i++) begin
      c  = random_cmd();
      op = c.op;
      run_cmd($sformatf("cmd %0d %s", i, op.name()), c);
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule
